// ==== src/cache_macros.svh ====
/* sizes and fixed encodings for the L1 caches; CACHE_SETS must be a power of two
   and the uncached bit must lie inside the tag field */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ----------------------------------------------------------------------
// datapath widths
`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32
`define CACHE_BE_W (`CACHE_DATA_W / 8)       // one enable per byte
`define CACHE_OFF_W $clog2(`CACHE_BE_W)      // byte offset inside a word

// ----------------------------------------------------------------------
// geometry and address map
`define CACHE_SETS 16                        // one word per line
`define CACHE_IDX_W $clog2(`CACHE_SETS)
`define CACHE_UNCACHED_BIT 31                // set = dcache bypass

// bus transaction ids
`define MEM_ID_ICACHE 1'b0
`define MEM_ID_DCACHE 1'b1

`endif

// ==== src/cache_pkg.sv ====
/* types shared by the cache RTL; index and tag split follows the widths in
   cache_macros.svh, the low address bits are the byte offset */
`include "cache_macros.svh"

package cache_pkg;

  // ----------------------------------------------------------------------
  // plain vectors
  typedef logic [`CACHE_ADDR_W-1:0] addr_t;    // byte address
  typedef logic [`CACHE_DATA_W-1:0] data_t;
  typedef logic [`CACHE_BE_W-1:0]   be_t;
  typedef logic [`CACHE_IDX_W-1:0]  idx_t;     // set index, bits 5:2
  typedef logic [`CACHE_ADDR_W-`CACHE_IDX_W-`CACHE_OFF_W-1:0] tag_t;
  typedef logic                     mem_id_t;  // which cache owns a bus transfer

  // ----------------------------------------------------------------------
  // state machines
  typedef enum logic [1:0] {
    IC_IDLE,
    IC_REFILL,  // read outstanding on the bus
    IC_FLUSH    // valid bits cleared this cycle
  } icache_state_e;

  typedef enum logic [2:0] {
    DC_IDLE,
    DC_MISS,      // line refill
    DC_WRITE,     // store goes through to memory
    DC_UNCACHED,  // load past the array
    DC_FLUSH
  } dcache_state_e;

  // address split
  function automatic idx_t addr_idx(addr_t a);
    return a[`CACHE_IDX_W+`CACHE_OFF_W-1:`CACHE_OFF_W];
  endfunction

  function automatic tag_t addr_tag(addr_t a);
    return a[`CACHE_ADDR_W-1:`CACHE_IDX_W+`CACHE_OFF_W];
  endfunction

endpackage

// ==== src/mem_bus_if.sv ====
/* one cache to arbiter link; request held stable until req_ready, rsp_valid is
   a one-cycle pulse per request and is never back-pressured */
interface mem_bus_if;
  import cache_pkg::*;

  // request channel, write data rides along
  logic  req_valid;
  logic  req_ready;
  logic  req_we;
  addr_t req_addr;   // word aligned
  data_t req_wdata;
  be_t   req_be;

  // response channel
  logic  rsp_valid;
  data_t rsp_rdata;  // undefined for writes

  modport client (
    output req_valid, req_we, req_addr, req_wdata, req_be,
    input  req_ready, rsp_valid, rsp_rdata
  );

  modport arbiter (
    input  req_valid, req_we, req_addr, req_wdata, req_be,
    output req_ready, rsp_valid, rsp_rdata
  );

endinterface

// ==== src/icache.sv ====
/* read-only direct-mapped icache, one fetch in flight; with en_i low every fetch
   reads the bus and the array is left alone */
`include "cache_macros.svh"

module icache (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             en_i,
  input  logic             flush_i,
  input  logic             req_i,
  input  cache_pkg::addr_t addr_i,
  output logic             ready_o,
  output logic             rvalid_o,
  output cache_pkg::data_t rdata_o,
  output logic             miss_o,
  output logic             busy_o,
  mem_bus_if.client        bus
);
  import cache_pkg::*;

  icache_state_e state_q;
  logic          pend_q;     // request not yet taken by the arbiter
  logic          fill_q;     // write line on response
  logic          rvalid_q;
  logic          miss_q;
  addr_t         addr_q;
  data_t         rdata_q;

  logic [`CACHE_SETS-1:0] valid_q;
  tag_t                   tag_q  [`CACHE_SETS];
  data_t                  data_q [`CACHE_SETS];

  idx_t idx;
  logic hit;
  logic accept;

  assign idx     = addr_idx(addr_i);
  assign hit     = en_i & valid_q[idx] & (tag_q[idx] == addr_tag(addr_i));
  assign ready_o = (state_q == IC_IDLE) & ~flush_i;  // flush wins over a fetch
  assign accept  = req_i & ready_o;

  // ----------------------------------------------------------------------
  // control
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= IC_FLUSH;  // first cycle out of reset wipes the valid bits
      pend_q   <= 1'b0;
      fill_q   <= 1'b0;
      rvalid_q <= 1'b0;
      miss_q   <= 1'b0;
    end else begin
      rvalid_q <= 1'b0;
      miss_q   <= 1'b0;
      case (state_q)
        IC_IDLE: begin
          if (flush_i) begin
            state_q <= IC_FLUSH;
          end else if (accept && hit) begin
            rvalid_q <= 1'b1;
          end else if (accept) begin
            state_q <= IC_REFILL;
            pend_q  <= 1'b1;
            fill_q  <= en_i;
            miss_q  <= en_i;  // bypass reads are not counted
          end
        end
        IC_REFILL: begin
          if (pend_q && bus.req_ready) pend_q <= 1'b0;
          if (bus.rsp_valid) begin
            state_q  <= IC_IDLE;
            rvalid_q <= 1'b1;
          end
        end
        default: state_q <= IC_IDLE;  // IC_FLUSH lasts one cycle
      endcase
    end
  end

  // payload and arrays
  always_ff @(posedge clk_i) begin
    if (accept) addr_q <= addr_i & ~addr_t'(`CACHE_BE_W - 1);
    if (accept && hit) rdata_q <= data_q[idx];
    else if (state_q == IC_REFILL && bus.rsp_valid) rdata_q <= bus.rsp_rdata;
    if (state_q == IC_FLUSH) begin
      valid_q <= '0;
    end else if (state_q == IC_REFILL && bus.rsp_valid && fill_q) begin
      valid_q[addr_idx(addr_q)] <= 1'b1;
      tag_q[addr_idx(addr_q)]   <= addr_tag(addr_q);
      data_q[addr_idx(addr_q)]  <= bus.rsp_rdata;
    end
  end

  assign bus.req_valid = pend_q;
  assign bus.req_we    = 1'b0;   // fetches only read
  assign bus.req_addr  = addr_q;
  assign bus.req_wdata = '0;
  assign bus.req_be    = '1;
  assign rvalid_o      = rvalid_q;
  assign rdata_o       = rdata_q;
  assign miss_o        = miss_q;
  assign busy_o        = (state_q == IC_REFILL);

  // a fetch is answered only once its bus request has been taken
  a_rvalid_no_req : assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_o |-> !bus.req_valid)
    else $error("icache: rvalid_o together with a bus request");

endmodule

// ==== src/dcache.sv ====
/* write-through dcache without write-allocate, one access in flight; flush_i is
   held until flush_ack_o, uncached or disabled accesses never touch the arrays */
`include "cache_macros.svh"

module dcache (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             en_i,
  input  logic             flush_i,
  output logic             flush_ack_o,
  input  logic             req_i,
  input  logic             we_i,
  input  cache_pkg::addr_t addr_i,
  input  cache_pkg::data_t wdata_i,
  input  cache_pkg::be_t   be_i,
  output logic             ready_o,
  output logic             rvalid_o,
  output cache_pkg::data_t rdata_o,
  output logic             miss_o,
  output logic             busy_o,
  mem_bus_if.client        bus
);
  import cache_pkg::*;

  dcache_state_e state_q;
  logic          pend_q;       // bus request waiting for ready
  logic          rvalid_q;
  logic          miss_q;
  logic          flush_ack_q;
  logic          we_q;
  addr_t         addr_q;
  data_t         wdata_q;
  be_t           be_q;
  data_t         rdata_q;

  logic [`CACHE_SETS-1:0] valid_q;
  tag_t                   tag_q  [`CACHE_SETS];
  data_t                  data_q [`CACHE_SETS];

  idx_t  idx;
  logic  cacheable;
  logic  hit;
  logic  flush_go;
  logic  accept;
  logic  rsp;
  data_t merged;   // hit line with the store bytes laid over it

  assign idx       = addr_idx(addr_i);
  assign cacheable = en_i & ~addr_i[`CACHE_UNCACHED_BIT];
  assign hit       = cacheable & valid_q[idx] & (tag_q[idx] == addr_tag(addr_i));
  assign flush_go  = flush_i & ~flush_ack_q;  // level still high in the ack cycle
  assign ready_o   = (state_q == DC_IDLE) & ~flush_go;
  assign accept    = req_i & ready_o;
  assign busy_o    = state_q inside {DC_MISS, DC_WRITE, DC_UNCACHED};
  assign rsp       = bus.rsp_valid & busy_o;

  always_comb begin
    merged = data_q[idx];
    for (int b = 0; b < `CACHE_BE_W; b++) begin
      if (be_i[b]) merged[8*b +: 8] = wdata_i[8*b +: 8];
    end
  end

  // ----------------------------------------------------------------------
  // control
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= DC_FLUSH;  // clears the valid bits, no ack without flush_i
      pend_q      <= 1'b0;
      rvalid_q    <= 1'b0;
      miss_q      <= 1'b0;
      flush_ack_q <= 1'b0;
    end else begin
      rvalid_q    <= 1'b0;
      miss_q      <= 1'b0;
      flush_ack_q <= 1'b0;
      case (state_q)
        DC_IDLE: begin
          if (flush_go) begin
            state_q <= DC_FLUSH;
          end else if (accept) begin
            if (we_i) begin
              state_q <= DC_WRITE;  // every store goes out
              pend_q  <= 1'b1;
            end else if (hit) begin
              rvalid_q <= 1'b1;
            end else if (cacheable) begin
              state_q <= DC_MISS;
              pend_q  <= 1'b1;
              miss_q  <= 1'b1;
            end else begin
              state_q <= DC_UNCACHED;
              pend_q  <= 1'b1;
            end
          end
        end
        DC_MISS, DC_WRITE, DC_UNCACHED: begin
          if (pend_q && bus.req_ready) pend_q <= 1'b0;
          if (bus.rsp_valid) begin
            state_q  <= DC_IDLE;
            rvalid_q <= 1'b1;
          end
        end
        default: begin  // DC_FLUSH
          state_q     <= DC_IDLE;
          flush_ack_q <= flush_i;
        end
      endcase
    end
  end

  // payload and arrays
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= addr_i & ~addr_t'(`CACHE_BE_W - 1);
      we_q    <= we_i;
      wdata_q <= wdata_i;
      be_q    <= we_i ? be_i : '1;  // reads fetch the whole word
    end
    if (accept && !we_i && hit) rdata_q <= data_q[idx];
    else if (rsp) rdata_q <= bus.rsp_rdata;
    if (state_q == DC_FLUSH) begin
      valid_q <= '0;
    end else if (accept && we_i && hit) begin
      data_q[idx] <= merged;  // store hit updates the line at once
    end else if (state_q == DC_MISS && bus.rsp_valid) begin
      valid_q[addr_idx(addr_q)] <= 1'b1;
      tag_q[addr_idx(addr_q)]   <= addr_tag(addr_q);
      data_q[addr_idx(addr_q)]  <= bus.rsp_rdata;
    end
  end

  assign bus.req_valid = pend_q;
  assign bus.req_we    = we_q;
  assign bus.req_addr  = addr_q;
  assign bus.req_wdata = wdata_q;
  assign bus.req_be    = be_q;
  assign rvalid_o      = rvalid_q;
  assign rdata_o       = rdata_q;
  assign miss_o        = miss_q;
  assign flush_ack_o   = flush_ack_q;

  a_ack_pulse : assert property (@(posedge clk_i) disable iff (reset_i)
    flush_ack_o |=> !flush_ack_o)
    else $error("dcache: flush_ack_o held for two cycles");

endmodule

// ==== src/mem_arbiter.sv ====
/* two-client round-robin onto one memory port, zero added latency; the id of a
   response must be the id its request carried */
`include "cache_macros.svh"

module mem_arbiter (
  input  logic               clk_i,
  input  logic               reset_i,
  mem_bus_if.arbiter         ic,
  mem_bus_if.arbiter         dc,
  output logic               mem_req_valid_o,
  output cache_pkg::mem_id_t mem_req_id_o,
  output logic               mem_req_we_o,
  output cache_pkg::addr_t   mem_req_addr_o,
  output cache_pkg::data_t   mem_req_wdata_o,
  output cache_pkg::be_t     mem_req_be_o,
  input  logic               mem_req_ready_i,
  input  logic               mem_rsp_valid_i,
  input  cache_pkg::mem_id_t mem_rsp_id_i,
  input  cache_pkg::data_t   mem_rsp_rdata_i
);
  import cache_pkg::*;

  mem_id_t grant_q;  // last client put on the bus
  logic    lock_q;   // grant stalled by memory, keep it
  mem_id_t sel;

  // ----------------------------------------------------------------------
  // grant
  always_comb begin
    if (lock_q) sel = grant_q;
    else if (ic.req_valid && dc.req_valid) begin
      sel = (grant_q == `MEM_ID_ICACHE) ? `MEM_ID_DCACHE : `MEM_ID_ICACHE;  // alternate
    end else if (dc.req_valid) sel = `MEM_ID_DCACHE;
    else sel = `MEM_ID_ICACHE;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      grant_q <= `MEM_ID_DCACHE;  // icache goes first on a tie
      lock_q  <= 1'b0;
    end else begin
      lock_q <= mem_req_valid_o & ~mem_req_ready_i;
      if (mem_req_valid_o) grant_q <= sel;
    end
  end

  // request mux, straight from the selected client
  always_comb begin
    if (sel == `MEM_ID_DCACHE) begin
      mem_req_valid_o = dc.req_valid;
      mem_req_we_o    = dc.req_we;
      mem_req_addr_o  = dc.req_addr;
      mem_req_wdata_o = dc.req_wdata;
      mem_req_be_o    = dc.req_be;
    end else begin
      mem_req_valid_o = ic.req_valid;
      mem_req_we_o    = ic.req_we;
      mem_req_addr_o  = ic.req_addr;
      mem_req_wdata_o = ic.req_wdata;
      mem_req_be_o    = ic.req_be;
    end
  end

  assign mem_req_id_o = sel;
  assign ic.req_ready = mem_req_ready_i & (sel == `MEM_ID_ICACHE);
  assign dc.req_ready = mem_req_ready_i & (sel == `MEM_ID_DCACHE);

  // response demux by id, data goes to both
  assign ic.rsp_valid = mem_rsp_valid_i & (mem_rsp_id_i == `MEM_ID_ICACHE);
  assign dc.rsp_valid = mem_rsp_valid_i & (mem_rsp_id_i == `MEM_ID_DCACHE);
  assign ic.rsp_rdata = mem_rsp_rdata_i;
  assign dc.rsp_rdata = mem_rsp_rdata_i;

  a_one_ready : assert property (@(posedge clk_i) disable iff (reset_i)
    !(ic.req_ready && dc.req_ready))
    else $error("arbiter: ready given to both clients");

  a_stall_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_id_o)
      && $stable(mem_req_we_o) && $stable(mem_req_addr_o)
      && $stable(mem_req_wdata_o) && $stable(mem_req_be_o))
    else $error("arbiter: request changed while stalled");

endmodule

// ==== src/cache_subsystem.sv ====
/* L1 subsystem, icache and dcache on one memory port; each cache has at most one
   bus transaction open and memory must echo the request id */
module cache_subsystem (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               icache_en_i,
  input  logic               icache_flush_i,
  input  logic               dcache_en_i,
  input  logic               dcache_flush_i,
  output logic               icache_miss_o,
  output logic               dcache_miss_o,
  output logic               dcache_flush_ack_o,
  output logic               busy_o,
  // fetch port
  input  logic               if_req_i,
  input  cache_pkg::addr_t   if_addr_i,
  output logic               if_ready_o,
  output logic               if_rvalid_o,
  output cache_pkg::data_t   if_rdata_o,
  // load/store port
  input  logic               d_req_i,
  input  logic               d_we_i,
  input  cache_pkg::addr_t   d_addr_i,
  input  cache_pkg::data_t   d_wdata_i,
  input  cache_pkg::be_t     d_be_i,
  output logic               d_ready_o,
  output logic               d_rvalid_o,
  output cache_pkg::data_t   d_rdata_o,
  // memory port
  output logic               mem_req_valid_o,
  output cache_pkg::mem_id_t mem_req_id_o,
  output logic               mem_req_we_o,
  output cache_pkg::addr_t   mem_req_addr_o,
  output cache_pkg::data_t   mem_req_wdata_o,
  output cache_pkg::be_t     mem_req_be_o,
  input  logic               mem_req_ready_i,
  input  logic               mem_rsp_valid_i,
  input  cache_pkg::mem_id_t mem_rsp_id_i,
  input  cache_pkg::data_t   mem_rsp_rdata_i
);

  mem_bus_if ic_bus ();
  mem_bus_if dc_bus ();
  logic      ic_busy;
  logic      dc_busy;

  assign busy_o = ic_busy | dc_busy;  // any bus transfer open

  icache u_icache (.clk_i, .reset_i, .en_i(icache_en_i), .flush_i(icache_flush_i),
    .req_i(if_req_i), .addr_i(if_addr_i), .ready_o(if_ready_o), .rvalid_o(if_rvalid_o),
    .rdata_o(if_rdata_o), .miss_o(icache_miss_o), .busy_o(ic_busy), .bus(ic_bus));

  dcache u_dcache (.clk_i, .reset_i, .en_i(dcache_en_i), .flush_i(dcache_flush_i),
    .flush_ack_o(dcache_flush_ack_o), .req_i(d_req_i), .we_i(d_we_i), .addr_i(d_addr_i),
    .wdata_i(d_wdata_i), .be_i(d_be_i), .ready_o(d_ready_o), .rvalid_o(d_rvalid_o),
    .rdata_o(d_rdata_o), .miss_o(dcache_miss_o), .busy_o(dc_busy), .bus(dc_bus));

  mem_arbiter u_arbiter (.clk_i, .reset_i, .ic(ic_bus), .dc(dc_bus), .mem_req_valid_o,
    .mem_req_id_o, .mem_req_we_o, .mem_req_addr_o, .mem_req_wdata_o, .mem_req_be_o,
    .mem_req_ready_i, .mem_rsp_valid_i, .mem_rsp_id_i, .mem_rsp_rdata_i);

endmodule

// ==== dv/tb_mem_model.sv ====
/* testbench memory, word granular; unwritten words read back a fixed address rule
   and at most one request per bus id may be open */
module tb_mem_model (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_valid_i,
  input  cache_pkg::mem_id_t req_id_i,
  input  logic               req_we_i,
  input  cache_pkg::addr_t   req_addr_i,
  input  cache_pkg::data_t   req_wdata_i,
  input  cache_pkg::be_t     req_be_i,
  output logic               req_ready_o,
  output logic               rsp_valid_o,
  output cache_pkg::mem_id_t rsp_id_o,
  output cache_pkg::data_t   rsp_rdata_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import cache_pkg::*;

  logic [31:0] lfsr_q;
  data_t       shadow [addr_t];  // written words only
  logic  [1:0] open_q;           // one slot per bus id
  int          wait_q [2];
  data_t       rdata_q [2];

  function automatic data_t initial_word(addr_t a);
    return {2'b00, a[31:2]} ^ 32'h5a5a0000;  // whole word address
  endfunction

  // fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int n, output logic [3:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[2:0], lfsr_q[0]};  // one step per bit
    end
  endtask

  // ----------------------------------------------------------------------
  // accept at the edge, answer 1 to 4 cycles later, drive 1 ns after the edge
  initial begin : serve
    logic [3:0] r;
    logic       rst;
    logic       rsp_n;
    mem_id_t    id_n;
    data_t      data_n;
    addr_t      wa;
    data_t      w;
    lfsr_q      = 32'hf0de2081;
    open_q      = '0;
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_id_o    = '0;
    rsp_rdata_o = '0;
    forever begin
      @(posedge clk_i);
      rst    = reset_i;
      rsp_n  = 1'b0;
      id_n   = '0;
      data_n = '0;
      if (rst) begin
        open_q = '0;
      end else begin
        for (int i = 0; i < 2; i++) begin
          if (open_q[i] && wait_q[i] > 0) wait_q[i]--;
        end
        if (req_valid_i && req_ready_o) begin
          wa = {req_addr_i[31:2], 2'b00};
          w  = shadow.exists(wa) ? shadow[wa] : initial_word(wa);
          if (req_we_i) begin
            for (int b = 0; b < 4; b++) begin
              if (req_be_i[b]) w[8*b +: 8] = req_wdata_i[8*b +: 8];
            end
            shadow[wa] = w;
          end
          draw(2, r);
          open_q[req_id_i]  = 1'b1;
          wait_q[req_id_i]  = int'(r[1:0]);  // 0 here means answer next cycle
          rdata_q[req_id_i] = w;
        end
        for (int i = 0; i < 2; i++) begin
          if (!rsp_n && open_q[i] && wait_q[i] == 0) begin  // id 0 first on a tie
            rsp_n     = 1'b1;
            id_n      = mem_id_t'(i);
            data_n    = rdata_q[i];
            open_q[i] = 1'b0;
          end
        end
      end
      draw(2, r);
      #1;
      req_ready_o = !rst && (r[1:0] != 2'b00);  // stall about one cycle in four
      rsp_valid_o = rsp_n;
      rsp_id_o    = id_n;
      rsp_rdata_o = data_n;
    end
  end

endmodule

// ==== dv/cache_subsystem_tb.sv ====
/* cache subsystem testbench; one request at a time per core port, expected data
   comes from a reference copy of the memory rule and of every store */
`include "cache_macros.svh"

module cache_subsystem_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cache_pkg::*;

  localparam addr_t unc_base = addr_t'(1) << `CACHE_UNCACHED_BIT;

  logic    clk_i;
  logic    reset_i;
  logic    icache_en_i;
  logic    icache_flush_i;
  logic    dcache_en_i;
  logic    dcache_flush_i;
  logic    icache_miss_o;
  logic    dcache_miss_o;
  logic    dcache_flush_ack_o;
  logic    busy_o;
  logic    if_req_i;
  addr_t   if_addr_i;
  logic    if_ready_o;
  logic    if_rvalid_o;
  data_t   if_rdata_o;
  logic    d_req_i;
  logic    d_we_i;
  addr_t   d_addr_i;
  data_t   d_wdata_i;
  be_t     d_be_i;
  logic    d_ready_o;
  logic    d_rvalid_o;
  data_t   d_rdata_o;
  logic    mem_req_valid_o;
  mem_id_t mem_req_id_o;
  logic    mem_req_we_o;
  addr_t   mem_req_addr_o;
  data_t   mem_req_wdata_o;
  be_t     mem_req_be_o;
  logic    mem_req_ready_i;
  logic    mem_rsp_valid_i;
  mem_id_t mem_rsp_id_i;
  data_t   mem_rsp_rdata_i;

  // scoreboard
  data_t ref_mem [addr_t];
  data_t if_exp_q [$];
  data_t d_exp_q [$];
  bit    d_chk_q [$];   // 0 for stores, rdata undefined
  data_t if_head;
  data_t d_head;
  logic  d_head_chk;
  int    if_cnt;
  int    d_cnt;
  int    issued;
  addr_t if_last_addr;  // word address of the last accepted request
  addr_t d_last_addr;
  logic  if_seen;
  logic  d_seen;

  // expectations armed by the stimulus
  logic if_miss_exp;
  logic if_hit_exp;
  logic d_miss_exp;
  logic d_hit_exp;
  logic d_bus_exp;
  logic idle_window;

  cache_subsystem u_dut (.*);

  tb_mem_model u_mem (.clk_i, .reset_i, .req_valid_i(mem_req_valid_o),
    .req_id_i(mem_req_id_o), .req_we_i(mem_req_we_o), .req_addr_i(mem_req_addr_o),
    .req_wdata_i(mem_req_wdata_o), .req_be_i(mem_req_be_o), .req_ready_o(mem_req_ready_i),
    .rsp_valid_o(mem_rsp_valid_i), .rsp_id_o(mem_rsp_id_i), .rsp_rdata_o(mem_rsp_rdata_i));

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns
  end

  // ----------------------------------------------------------------------
  // reporting
  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic value_error(input string sig, input data_t got, input data_t exp);
    $display("** Error [%0t] %s: got %h, expected %h", $time, sig, got, exp);
    abort_run();
  endtask

  task automatic plain_error(input string what);
    $display("Failure at %0t: %s", $time, what);
    abort_run();
  endtask

  // ----------------------------------------------------------------------
  // reference memory
  function automatic data_t initial_word(addr_t a);
    return {2'b00, a[31:2]} ^ 32'h5a5a0000;
  endfunction

  function automatic data_t ref_read(addr_t a);
    addr_t wa;
    wa = {a[31:2], 2'b00};
    return ref_mem.exists(wa) ? ref_mem[wa] : initial_word(wa);
  endfunction

  task automatic ref_write(input addr_t a, input data_t wd, input be_t be);
    data_t w;
    w = ref_read(a);
    for (int b = 0; b < `CACHE_BE_W; b++) begin
      if (be[b]) w[8*b +: 8] = wd[8*b +: 8];  // byte merge
    end
    ref_mem[{a[31:2], 2'b00}] = w;
  endtask

  // queue heads follow every push and pop
  task automatic expect_fetch(input data_t v);
    if_exp_q.push_back(v);
    if_cnt  = if_exp_q.size();
    if_head = if_exp_q[0];
  endtask

  task automatic pop_fetch();
    void'(if_exp_q.pop_front());
    if_cnt = if_exp_q.size();
    if (if_cnt != 0) if_head = if_exp_q[0];
  endtask

  task automatic expect_data(input bit chk, input data_t v);
    d_exp_q.push_back(v);
    d_chk_q.push_back(chk);
    d_cnt      = d_exp_q.size();
    d_head     = d_exp_q[0];
    d_head_chk = d_chk_q[0];
  endtask

  task automatic pop_data();
    void'(d_exp_q.pop_front());
    void'(d_chk_q.pop_front());
    d_cnt = d_exp_q.size();
    if (d_cnt != 0) begin
      d_head     = d_exp_q[0];
      d_head_chk = d_chk_q[0];
    end
  endtask

  // rvalid seen at an edge retires the head 1 ns later
  initial forever begin
    @(posedge clk_i);
    if_seen = if_rvalid_o && !reset_i;
    d_seen  = d_rvalid_o && !reset_i;
    #1;
    if (if_seen && if_cnt != 0) pop_fetch();
    if (d_seen && d_cnt != 0) pop_data();
  end

  // ----------------------------------------------------------------------
  // core port drivers, entered 1 ns after an edge
  task automatic fetch(input addr_t a);
    if_req_i  = 1'b1;
    if_addr_i = a;
    issued++;
    @(posedge clk_i);
    while (!if_ready_o) @(posedge clk_i);
    #1;
    if_req_i     = 1'b0;
    if_last_addr = {a[31:2], 2'b00};
    expect_fetch(ref_read(a));
    @(posedge clk_i);
    while (!if_rvalid_o) @(posedge clk_i);
    #1;
  endtask

  task automatic data_access(input logic we, input addr_t a, input data_t wd, input be_t be);
    d_req_i   = 1'b1;
    d_we_i    = we;
    d_addr_i  = a;
    d_wdata_i = wd;
    d_be_i    = be;
    issued++;
    @(posedge clk_i);
    while (!d_ready_o) @(posedge clk_i);
    #1;
    d_req_i     = 1'b0;
    d_last_addr = {a[31:2], 2'b00};
    if (we) begin
      ref_write(a, wd, be);
      expect_data(1'b0, '0);
    end else begin
      expect_data(1'b1, ref_read(a));
    end
    @(posedge clk_i);
    while (!d_rvalid_o) @(posedge clk_i);
    #1;
  endtask

  task automatic load(input addr_t a);
    data_access(1'b0, a, '0, '0);
  endtask

  task automatic store(input addr_t a, input data_t wd, input be_t be);
    data_access(1'b1, a, wd, be);
  endtask

  task automatic flush_dcache();
    dcache_flush_i = 1'b1;  // level, held until ack
    issued++;
    @(posedge clk_i);
    while (!dcache_flush_ack_o) @(posedge clk_i);
    #1;
    dcache_flush_i = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // checkers
  a_if_data : assert property (@(posedge clk_i) disable iff (reset_i)
    if_rvalid_o |-> if_rdata_o == if_head)
    else value_error("if_rdata_o", $sampled(if_rdata_o), if_head);

  a_d_data : assert property (@(posedge clk_i) disable iff (reset_i)
    d_rvalid_o && d_head_chk |-> d_rdata_o == d_head)
    else value_error("d_rdata_o", $sampled(d_rdata_o), d_head);

  a_if_extra : assert property (@(posedge clk_i) disable iff (reset_i)
    if_rvalid_o |-> if_cnt != 0)
    else plain_error("fetch rvalid with no fetch outstanding");

  a_d_extra : assert property (@(posedge clk_i) disable iff (reset_i)
    d_rvalid_o |-> d_cnt != 0)
    else plain_error("data rvalid with no access outstanding");

  a_if_hit : assert property (@(posedge clk_i) disable iff (reset_i)
    if_hit_exp && if_req_i && if_ready_o |=>
      if_rvalid_o && !icache_miss_o && !(mem_req_valid_o && mem_req_id_o == 1'b0))
    else plain_error("icache hit was not answered in one cycle without the bus");

  a_if_miss : assert property (@(posedge clk_i) disable iff (reset_i)
    if_miss_exp && if_req_i && if_ready_o |=>
      icache_miss_o && busy_o && mem_req_valid_o && mem_req_id_o == 1'b0)
    else plain_error("icache miss gave no miss pulse, no busy or no bus read");

  a_d_hit : assert property (@(posedge clk_i) disable iff (reset_i)
    d_hit_exp && d_req_i && d_ready_o |=> d_rvalid_o && !dcache_miss_o && !mem_req_valid_o)
    else plain_error("dcache hit was not answered in one cycle without the bus");

  a_d_miss : assert property (@(posedge clk_i) disable iff (reset_i)
    d_miss_exp && d_req_i && d_ready_o |=>
      dcache_miss_o && busy_o && mem_req_valid_o && mem_req_id_o == 1'b1)
    else plain_error("dcache miss gave no miss pulse, no busy or no bus read");

  a_d_bus : assert property (@(posedge clk_i) disable iff (reset_i)
    d_bus_exp && d_req_i && d_ready_o |=> !dcache_miss_o && busy_o && mem_req_valid_o
      && mem_req_id_o == 1'b1 && mem_req_addr_o == d_last_addr)
    else plain_error("uncached or disabled access did not go to the bus");

  // id must name the cache whose request is on the bus
  a_req_id : assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_valid_o |-> (mem_req_id_o == 1'b1) ? (mem_req_addr_o == d_last_addr)
      : (mem_req_addr_o == if_last_addr && !mem_req_we_o))
    else plain_error("bus request id does not match the requesting cache");

  a_req_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_id_o)
      && $stable(mem_req_we_o) && $stable(mem_req_addr_o)
      && $stable(mem_req_wdata_o) && $stable(mem_req_be_o))
    else plain_error("bus request changed while ready was low");

  a_idle : assert property (@(posedge clk_i) disable iff (reset_i)
    idle_window |-> !(if_rvalid_o || d_rvalid_o || mem_req_valid_o || icache_miss_o
      || dcache_miss_o || dcache_flush_ack_o || busy_o))
    else plain_error("control output active after reset before any request");

  a_reset_ready : assert property (@(posedge clk_i) $fell(reset_i) |-> !if_ready_o && !d_ready_o)
    else plain_error("cache ready in the first cycle after reset");

  // ----------------------------------------------------------------------
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < 200 * (issued + 1)) begin  // budget grows with each request
      @(posedge clk_i);
      cycles++;
    end
    plain_error($sformatf("no progress after %0d cycles, the DUT seems hung", cycles));
  end

  initial begin : stimulus
    reset_i        = 1'b1;
    icache_en_i    = 1'b1;
    icache_flush_i = 1'b0;
    dcache_en_i    = 1'b1;
    dcache_flush_i = 1'b0;
    if_req_i       = 1'b0;
    if_addr_i      = '0;
    d_req_i        = 1'b0;
    d_we_i         = 1'b0;
    d_addr_i       = '0;
    d_wdata_i      = '0;
    d_be_i         = '0;
    if_miss_exp    = 1'b0;
    if_hit_exp     = 1'b0;
    d_miss_exp     = 1'b0;
    d_hit_exp      = 1'b0;
    d_bus_exp      = 1'b0;
    idle_window    = 1'b0;
    if_cnt         = 0;
    d_cnt          = 0;
    issued         = 0;
    if_head        = '0;
    d_head         = '0;
    d_head_chk     = 1'b0;
    if_last_addr   = '0;
    d_last_addr    = '0;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i     = 1'b0;
    idle_window = 1'b1;  // quiet outputs until the first request
    repeat (4) @(posedge clk_i);
    #1;
    idle_window = 1'b0;

    // fetch miss, then hits on the same word
    if_miss_exp = 1'b1;
    fetch(32'h40);
    if_miss_exp = 1'b0;
    if_hit_exp  = 1'b1;
    fetch(32'h40);
    fetch(32'h42);
    if_hit_exp  = 1'b0;
    fetch(32'h44);

    // loads and stores, cached line then uncached line
    d_miss_exp = 1'b1;
    load(32'h100);
    d_miss_exp = 1'b0;
    d_hit_exp  = 1'b1;
    load(32'h100);
    d_hit_exp  = 1'b0;
    store(32'h100, 32'hdeadbeef, 4'b0110);
    d_hit_exp  = 1'b1;
    load(32'h100);       // merged line
    d_hit_exp  = 1'b0;
    d_miss_exp = 1'b1;
    load(32'h104);
    d_miss_exp = 1'b0;
    store(32'h200, 32'h11223344, 4'b1001);  // line not present, memory only
    d_miss_exp = 1'b1;
    load(32'h200);
    d_miss_exp = 1'b0;
    load(32'h1fc);
    load(32'h203);

    // uncached window and dcache disabled, bus every time
    d_bus_exp = 1'b1;
    load(unc_base | 32'h100);
    load(unc_base | 32'h100);
    store(unc_base | 32'h100, 32'hcafef00d, 4'b1100);
    load(unc_base | 32'h100);
    dcache_en_i = 1'b0;
    load(32'h100);
    load(32'h100);
    dcache_en_i = 1'b1;
    d_bus_exp   = 1'b0;

    // flushes
    icache_flush_i = 1'b1;
    issued++;
    @(posedge clk_i);
    #1;
    icache_flush_i = 1'b0;
    if_miss_exp    = 1'b1;
    fetch(32'h40);
    if_miss_exp    = 1'b0;
    flush_dcache();
    d_miss_exp = 1'b1;
    load(32'h100);
    d_miss_exp = 1'b0;

    // both caches missing at once under ready stalls
    fork
      begin
        for (int i = 0; i < 6; i++) fetch(32'h1000 + 4 * i);
      end
      begin
        for (int i = 0; i < 6; i++) load(32'h2000 + 4 * i);
        store(32'h2008, 32'ha5a5a5a5, 4'b0011);
        load(32'h2008);
      end
    join

    repeat (5) @(posedge clk_i);
    #1;
    if (if_cnt != 0 || d_cnt != 0) begin
      plain_error("responses missing at the end of the test");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+src
src/cache_pkg.sv
src/mem_bus_if.sv
src/icache.sv
src/dcache.sv
src/mem_arbiter.sv
src/cache_subsystem.sv
dv/tb_mem_model.sv
dv/cache_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f files.f \
  --top-module cache_subsystem_tb -o sim

# the simulator status is masked by tee, the log decides
./obj_dir/sim 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
grep -q "RESULT: PASS" sim.log
